/* hdl/nn_consts.svh */
`ifndef NN_CONSTS_SVH
`define NN_CONSTS_SVH

// layer dimensions.
`define NN_INPUTS 15
`define NN_NEURONS 6

// every activation, weight, bias and sum is this wide.
`define NN_WIDTH 16

// weight slot number that addresses the bias register.
// Slots 0 to NN_INPUTS-1 are the input weights.
`define NN_BIAS_SLOT `NN_INPUTS

`endif

/* hdl/nnDataPkg.sv */
`default_nettype none

`include "nn_consts.svh"

package nnDataPkg;

	// one input activation, two's complement.
	typedef logic signed [`NN_WIDTH-1:0] activation_t;

	// a weight or a bias, same format as the activations.
	typedef logic signed [`NN_WIDTH-1:0] weight_t;

	// accumulator value.
	// Products keep only their low bits and the sum wraps modulo 2^NN_WIDTH,
	// so the accumulator is no wider than the data.
	typedef logic signed [`NN_WIDTH-1:0] sum_t;

	// full input vector, element i is the i-th activation received.
	typedef activation_t [`NN_INPUTS-1:0] actVector_t;

	// one result per neuron, element n belongs to neuron n.
	typedef activation_t [`NN_NEURONS-1:0] layerResult_t;

endpackage

`default_nettype wire

/* hdl/nnCtrlPkg.sv */
`default_nettype none

`include "nn_consts.svh"

package nnCtrlPkg;

	import nnDataPkg::*;

	// selects one neuron of the layer.
	typedef logic [$clog2(`NN_NEURONS)-1:0] neuronIdx_t;

	// selects a weight slot, or the bias at NN_BIAS_SLOT.
	typedef logic [$clog2(`NN_BIAS_SLOT + 1)-1:0] slotIdx_t;

	// one weight or bias write as it arrives at the layer.
	typedef struct packed
	{
		neuronIdx_t neuron;
		slotIdx_t slot;
		weight_t value;
	} weightWrite_t;

	// result serializer states.
	typedef enum logic
	{
		IDLE,
		EMIT
	} serState_t;

endpackage

`default_nettype wire

/* hdl/layerFeeder.sv */
`timescale 1ns/1ns
`default_nettype none

`include "nn_consts.svh"

module layerFeeder
	import nnDataPkg::*;
	import nnCtrlPkg::*;
(
	input wire logic clk,
	input wire logic reset,

	// serial activations.
	input wire logic actStrobe,
	input wire activation_t actData,

	// weight and bias writes.
	input wire logic wStrobe,
	input wire weightWrite_t wData,

	// assembled vector to every neuron.
	output logic vecStrobe,
	output actVector_t vecData,

	// decoded weight write, shared by all neurons.
	output logic [`NN_NEURONS-1:0] wEnable,
	output slotIdx_t wSlot,
	output weight_t wValue
);

	localparam slotIdx_t LAST_INPUT = slotIdx_t'(`NN_INPUTS - 1);

	slotIdx_t inCount;
	actVector_t vecReg;

	// new activations enter at the top and move down.
	// After a full vector the first arrival sits in element 0.
	always_ff @(posedge clk)
	begin
		if (actStrobe)
		begin
			vecReg <= {actData, vecReg[`NN_INPUTS-1:1]};
		end
	end

	// input count and the vector strobe.
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			inCount <= '0;
			vecStrobe <= 1'b0;
		end
		else
		begin
			vecStrobe <= 1'b0;
			if (actStrobe)
			begin
				if (inCount == LAST_INPUT)
				begin
					inCount <= '0;
					vecStrobe <= 1'b1;
				end
				else
				begin
					inCount <= inCount + 1'b1;
				end
			end
		end
	end

	assign vecData = vecReg;

	// one-hot neuron enable.
	// A neuron number past the last neuron matches no bit.
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			wEnable <= '0;
		end
		else
		begin
			for (int n = 0; n < `NN_NEURONS; n++)
			begin
				wEnable[n] <= wStrobe && (wData.neuron == neuronIdx_t'(n));
			end
		end
	end

	// slot and value are only looked at with an enable.
	always_ff @(posedge clk)
	begin
		if (wStrobe)
		begin
			wSlot <= wData.slot;
			wValue <= wData.value;
		end
	end

endmodule

`default_nettype wire

/* hdl/neuronNode.sv */
`timescale 1ns/1ns
`default_nettype none

`include "nn_consts.svh"

module neuronNode
	import nnDataPkg::*;
	import nnCtrlPkg::*;
(
	input wire logic clk,
	input wire logic reset,

	// input vector from the feeder.
	input wire logic vecStrobe,
	input wire actVector_t vecData,

	// weight write port.
	input wire logic wEnable,
	input wire slotIdx_t wSlot,
	input wire weight_t wValue,

	// ReLU output.
	output logic resValid,
	output activation_t result
);

	// weight and bias registers.
	weight_t weights [`NN_INPUTS];
	weight_t bias;

	// stage one, captured activations.
	actVector_t actReg;
	logic actValid;

	// stage two, wrapped sum.
	sum_t products [`NN_INPUTS];
	sum_t sumNext;
	sum_t sumReg;
	logic sumValid;

	// weights are written by slot, the top slot is the bias.
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < `NN_INPUTS; i++)
			begin
				weights[i] <= '0;
			end
			bias <= '0;
		end
		else if (wEnable)
		begin
			if (wSlot == slotIdx_t'(`NN_BIAS_SLOT))
			begin
				bias <= wValue;
			end
			else
			begin
				weights[wSlot] <= wValue;
			end
		end
	end

	// stage one.
	always_ff @(posedge clk)
	begin
		if (vecStrobe)
		begin
			actReg <= vecData;
		end
	end

	// products keep their low bits only.
	always_comb
	begin
		for (int i = 0; i < `NN_INPUTS; i++)
		begin
			products[i] = actReg[i] * weights[i];
		end
	end

	// adder tree, wraps modulo 2^NN_WIDTH.
	always_comb
	begin
		sumNext = bias;
		for (int i = 0; i < `NN_INPUTS; i++)
		begin
			sumNext = sumNext + products[i];
		end
	end

	// stage two.
	always_ff @(posedge clk)
	begin
		sumReg <= sumNext;
	end

	// stage three, ReLU on the sign bit.
	always_ff @(posedge clk)
	begin
		if (sumReg[`NN_WIDTH-1])
		begin
			result <= '0;
		end
		else
		begin
			result <= activation_t'(sumReg);
		end
	end

	// valid bit follows the data down the pipe.
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			actValid <= 1'b0;
			sumValid <= 1'b0;
			resValid <= 1'b0;
		end
		else
		begin
			actValid <= vecStrobe;
			sumValid <= actValid;
			resValid <= sumValid;
		end
	end

endmodule

`default_nettype wire

/* hdl/resultSerializer.sv */
`timescale 1ns/1ns
`default_nettype none

`include "nn_consts.svh"

module resultSerializer
	import nnDataPkg::*;
	import nnCtrlPkg::*;
(
	input wire logic clk,
	input wire logic reset,

	// parallel results, all neurons in lockstep.
	input wire logic resValid,
	input wire layerResult_t results,

	// serial output.
	output logic outStrobe,
	output neuronIdx_t outIndex,
	output activation_t outData
);

	localparam neuronIdx_t LAST_NEURON = neuronIdx_t'(`NN_NEURONS - 1);

	serState_t state;
	neuronIdx_t emitIdx;
	layerResult_t holdReg;

	// captured results, held while they drain.
	always_ff @(posedge clk)
	begin
		if (resValid)
		begin
			holdReg <= results;
		end
	end

	// FSM.
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= IDLE;
			emitIdx <= '0;
		end
		else
		begin
			case (state)
				IDLE:
				begin
					if (resValid)
					begin
						state <= EMIT;
						emitIdx <= '0;
					end
				end
				EMIT:
				begin
					if (emitIdx == LAST_NEURON)
					begin
						state <= IDLE;
						emitIdx <= '0;
					end
					else
					begin
						emitIdx <= emitIdx + 1'b1;
					end
				end
				default:
				begin
					state <= IDLE;
					emitIdx <= '0;
				end
			endcase
		end
	end

	// one element per cycle while emitting.
	assign outStrobe = (state == EMIT);
	assign outIndex = emitIdx;
	assign outData = holdReg[emitIdx];

endmodule

`default_nettype wire

/* hdl/denseLayer.sv */
`timescale 1ns/1ns
`default_nettype none

`include "nn_consts.svh"

module denseLayer
	import nnDataPkg::*;
	import nnCtrlPkg::*;
(
	input wire logic clk,
	input wire logic reset,

	// activations, one per strobe.
	input wire logic actStrobe,
	input wire activation_t actData,

	// weight and bias writes.
	input wire logic wStrobe,
	input wire weightWrite_t wData,

	// results, one neuron per pulse.
	output logic outStrobe,
	output neuronIdx_t outIndex,
	output activation_t outData
);

	logic vecStrobe;
	actVector_t vecData;

	logic [`NN_NEURONS-1:0] wEnable;
	slotIdx_t wSlot;
	weight_t wValue;

	logic [`NN_NEURONS-1:0] resValid;
	layerResult_t results;

	layerFeeder u_layerFeeder
	(
		.clk(clk),
		.reset(reset),
		.actStrobe(actStrobe),
		.actData(actData),
		.wStrobe(wStrobe),
		.wData(wData),
		.vecStrobe(vecStrobe),
		.vecData(vecData),
		.wEnable(wEnable),
		.wSlot(wSlot),
		.wValue(wValue)
	);

	// all neurons see the same vector and write bus.
	for (genvar n = 0; n < `NN_NEURONS; n++)
	begin : genNeuron
		neuronNode u_neuronNode
		(
			.clk(clk),
			.reset(reset),
			.vecStrobe(vecStrobe),
			.vecData(vecData),
			.wEnable(wEnable[n]),
			.wSlot(wSlot),
			.wValue(wValue),
			.resValid(resValid[n]),
			.result(results[n])
		);
	end

	// neurons run in lockstep, so neuron 0 speaks for all.
	resultSerializer u_resultSerializer
	(
		.clk(clk),
		.reset(reset),
		.resValid(resValid[0]),
		.results(results),
		.outStrobe(outStrobe),
		.outIndex(outIndex),
		.outData(outData)
	);

endmodule

`default_nettype wire

/* verif/denseLayerTb.sv */
`timescale 1ns/1ns
`default_nettype none

`include "nn_consts.svh"

module denseLayerTb
	import nnDataPkg::*;
	import nnCtrlPkg::*;
();

	localparam int OUT_TIMEOUT = 60;
	localparam int DRAIN_TIMEOUT = 400;
	localparam int SEARCH_LIMIT = 100;

	logic clk;
	logic reset;
	logic actStrobe;
	activation_t actData;
	logic wStrobe;
	weightWrite_t wData;
	logic outStrobe;
	neuronIdx_t outIndex;
	activation_t outData;

	// copy of every weight and bias the DUT should hold.
	weight_t refWeights [`NN_NEURONS][`NN_INPUTS];
	weight_t refBias [`NN_NEURONS];

	neuronIdx_t expIndex [$];
	activation_t expData [$];
	logic [31:0] rngState;

	denseLayer u_denseLayer
	(
		.clk(clk),
		.reset(reset),
		.actStrobe(actStrobe),
		.actData(actData),
		.wStrobe(wStrobe),
		.wData(wData),
		.outStrobe(outStrobe),
		.outIndex(outIndex),
		.outData(outData)
	);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic logic [31:0] nextRandom();
		rngState = rngState ^ (rngState << 13);
		rngState = rngState ^ (rngState >> 17);
		rngState = rngState ^ (rngState << 5);
		return rngState;
	endfunction

	// uniform signed value of the given width.
	function automatic weight_t randomValue(input int bits);
		logic [31:0] r;
		int v;
		r = nextRandom();
		v = int'(r % (32'd1 << bits)) - (1 << (bits - 1));
		return weight_t'(v);
	endfunction

	function automatic actVector_t randomVector(input int bits);
		actVector_t v;
		for (int i = 0; i < `NN_INPUTS; i++)
		begin
			v[i] = activation_t'(randomValue(bits));
		end
		return v;
	endfunction

	// low half of each full product, sum wraps at 16 bits, then ReLU.
	function automatic activation_t neuronRef(input int n, input actVector_t vec);
		sum_t acc;
		logic signed [31:0] a;
		logic signed [31:0] w;
		logic signed [31:0] prod;
		acc = sum_t'(refBias[n]);
		for (int i = 0; i < `NN_INPUTS; i++)
		begin
			a = vec[i];
			w = refWeights[n][i];
			prod = a * w;
			acc = acc + sum_t'(prod[`NN_WIDTH-1:0]);
		end
		if (acc[`NN_WIDTH-1])
		begin
			return '0;
		end
		else
		begin
			return activation_t'(acc);
		end
	endfunction

	task automatic stopOnFailure();
		$display("TESTS FAILED");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic checkIndex(input string name, input neuronIdx_t got, input neuronIdx_t exp);
		if (got !== exp)
		begin
			$display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
			stopOnFailure();
		end
	endtask

	task automatic checkData(input string name, input activation_t got, input activation_t exp);
		if (got !== exp)
		begin
			$display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
			stopOnFailure();
		end
	endtask

	// inputs change shortly after the rising edge.
	task automatic waitDriveTime();
		@(posedge clk);
		#2;
	endtask

	task automatic idleCycles(input int n);
		repeat (n)
		begin
			waitDriveTime();
			actStrobe = 1'b0;
			wStrobe = 1'b0;
		end
	endtask

	task automatic writeWeight(input int n, input int s, input weight_t v);
		waitDriveTime();
		actStrobe = 1'b0;
		wStrobe = 1'b1;
		wData.neuron = neuronIdx_t'(n);
		wData.slot = slotIdx_t'(s);
		wData.value = v;
		// out-of-range neurons must change nothing.
		if (n < `NN_NEURONS)
		begin
			if (s == `NN_BIAS_SLOT)
			begin
				refBias[n] = v;
			end
			else
			begin
				refWeights[n][s] = v;
			end
		end
	endtask

	task automatic loadRandomWeights(input int bits);
		for (int n = 0; n < `NN_NEURONS; n++)
		begin
			for (int s = 0; s <= `NN_BIAS_SLOT; s++)
			begin
				writeWeight(n, s, randomValue(bits));
			end
		end
		idleCycles(1);
	endtask

	task automatic pushExpected(input actVector_t vec);
		for (int n = 0; n < `NN_NEURONS; n++)
		begin
			expIndex.push_back(neuronIdx_t'(n));
			expData.push_back(neuronRef(n, vec));
		end
	endtask

	// strobe stays high after the last activation until the next drive.
	task automatic sendVector(input actVector_t vec, input int maxGap);
		int gap;
		for (int i = 0; i < `NN_INPUTS; i++)
		begin
			waitDriveTime();
			wStrobe = 1'b0;
			actStrobe = 1'b1;
			actData = vec[i];
			if (maxGap > 0 && i < `NN_INPUTS - 1)
			begin
				gap = int'(nextRandom() % (maxGap + 1));
				repeat (gap)
				begin
					waitDriveTime();
					actStrobe = 1'b0;
				end
			end
		end
		pushExpected(vec);
	endtask

	task automatic waitDrain();
		int cycles;
		cycles = 0;
		while (expIndex.size() != 0)
		begin
			@(posedge clk);
			cycles++;
			if (cycles > DRAIN_TIMEOUT)
			begin
				$display("timeout: results still pending after %0d cycles", cycles);
				stopOnFailure();
			end
		end
	endtask

	// compares every output pulse with the oldest pending result.
	initial
	begin : compareOutputs
		int idle;
		idle = 0;
		forever
		begin
			@(negedge clk);
			if (!reset)
			begin
				if (outStrobe === 1'b1)
				begin
					idle = 0;
					if (expIndex.size() == 0)
					begin
						$display("output pulse seen while no result was pending");
						stopOnFailure();
					end
					else
					begin
						checkIndex("outIndex", outIndex, expIndex.pop_front());
						checkData("outData", outData, expData.pop_front());
					end
				end
				else if (outStrobe !== 1'b0)
				begin
					$display("outStrobe is unknown after reset");
					stopOnFailure();
				end
				else if (expIndex.size() != 0)
				begin
					idle++;
					if (idle > OUT_TIMEOUT)
					begin
						$display("timeout: no output pulse for %0d cycles", idle);
						stopOnFailure();
					end
				end
			end
		end
	end

	initial
	begin : runTests
		actVector_t vec;
		weight_t oldWeight;
		weight_t newWeight;
		activation_t oldResult;
		activation_t newResult;
		int tries;
		rngState = 32'hcfbe;
		reset = 1'b1;
		actStrobe = 1'b0;
		actData = '0;
		wStrobe = 1'b0;
		wData = '0;
		for (int n = 0; n < `NN_NEURONS; n++)
		begin
			refBias[n] = '0;
			for (int i = 0; i < `NN_INPUTS; i++)
			begin
				refWeights[n][i] = '0;
			end
		end
		repeat (10) @(posedge clk);
		#2;
		reset = 1'b0;

		// reset state, all weights zero.
		idleCycles(20);
		sendVector(randomVector(16), 0);
		idleCycles(1);
		waitDrain();

		// small weights, gaps between strobes.
		loadRandomWeights(4);
		writeWeight(7, 3, weight_t'(16'h7fff));
		idleCycles(1);
		repeat (4) sendVector(randomVector(8), 3);
		idleCycles(1);
		waitDrain();

		// odd neurons get negative sums.
		for (int n = 0; n < `NN_NEURONS; n++)
		begin
			for (int s = 0; s < `NN_INPUTS; s++)
			begin
				writeWeight(n, s, (n % 2 == 0) ? weight_t'(1) : weight_t'(-1));
			end
			writeWeight(n, `NN_BIAS_SLOT, weight_t'(n * 5));
		end
		idleCycles(1);
		repeat (3)
		begin
			for (int i = 0; i < `NN_INPUTS; i++)
			begin
				vec[i] = activation_t'(nextRandom() % 200 + 1);
			end
			sendVector(vec, 1);
		end
		idleCycles(1);
		waitDrain();

		// full range, products and sums wrap.
		loadRandomWeights(16);
		repeat (5) sendVector(randomVector(16), 2);
		idleCycles(1);
		waitDrain();

		// back-to-back vectors.
		repeat (6) sendVector(randomVector(16), 0);
		idleCycles(1);
		waitDrain();

		// rewrite one weight of neuron 2 between two equal vectors.
		// the vector must make neuron 2 answer differently after the rewrite.
		oldWeight = refWeights[2][7];
		newWeight = oldWeight + weight_t'(16'h0123);
		tries = 0;
		do
		begin
			vec = randomVector(12);
			vec[7] = activation_t'(16'h0011);
			oldResult = neuronRef(2, vec);
			refWeights[2][7] = newWeight;
			newResult = neuronRef(2, vec);
			refWeights[2][7] = oldWeight;
			tries++;
		end
		while (oldResult == newResult && tries < SEARCH_LIMIT);
		if (oldResult == newResult)
		begin
			$display("no vector found whose result shows the weight rewrite");
			stopOnFailure();
		end
		sendVector(vec, 0);
		idleCycles(1);
		waitDrain();
		writeWeight(2, 7, newWeight);
		idleCycles(1);
		sendVector(vec, 0);
		idleCycles(1);
		waitDrain();

		idleCycles(20);
		$display("TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* denseLayer.f */
+incdir+hdl
hdl/nnDataPkg.sv
hdl/nnCtrlPkg.sv
hdl/layerFeeder.sv
hdl/neuronNode.sv
hdl/resultSerializer.sv
hdl/denseLayer.sv
verif/denseLayerTb.sv

/* Bender.yml */
package:
  name: dense_layer

sources:
  # RTL, packages first.
  - include_dirs:
      - hdl
    files:
      - hdl/nnDataPkg.sv
      - hdl/nnCtrlPkg.sv
      - hdl/layerFeeder.sv
      - hdl/neuronNode.sv
      - hdl/resultSerializer.sv
      - hdl/denseLayer.sv

  # testbench.
  - target: test
    include_dirs:
      - hdl
    files:
      - verif/denseLayerTb.sv
